//--- Bender.yml
package:
  name: core_shell

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/bridge_pkg.sv
      - common/av_pkg.sv
      - design/bridge/bridge_regs.sv
      - design/pad_mapper.sv
      - design/video/video_conditioner.sv
      - design/core_shell_top.sv

  - target: test
    include_dirs:
      - common
    files:
      - test/tb_core_shell.sv

//--- common/av_pkg.sv
////////////////////////////////////////////////////////////////////////////
// player and video side types
// controller pads plus raw core video and scaler video
////////////////////////////////////////////////////////////////////////////

`include "core_cfg.svh"

package av_pkg;

  // one player pad as the core sees it
  typedef struct packed {
    logic a;
    logic b;
    logic start;
    logic select;
    logic up;
    logic down;
    logic left;
    logic right;
  } pad_t;

  // video straight out of the emulator core
  typedef struct packed {
    logic                  h_blank;
    logic                  v_blank;
    logic                  hs;
    logic                  vs;
    logic [`CFG_RGB_W-1:0] rgb;
  } raw_video_t;

  // video as the scaler expects it
  typedef struct packed {
    logic                  de;
    logic                  hs;
    logic                  vs;
    logic [`CFG_RGB_W-1:0] rgb;
  } scaler_video_t;

endpackage

//--- common/bridge_pkg.sv
////////////////////////////////////////////////////////////////////////////
// bridge side types
// core settings, register select and external read sources
////////////////////////////////////////////////////////////////////////////

package bridge_pkg;

  // settings written by the host over the bridge
  typedef struct packed {
    logic       hide_overscan;
    logic [1:0] mask_vid_edges;
    logic       allow_extra_sprites;
    logic [2:0] selected_palette;
    logic       multitap_enabled;
    // swap face buttons on player 1
    logic       yb_map;
  } core_settings_t;

  // write target, decoded from bridge_addr
  typedef enum logic [2:0] {
    sel_none,
    sel_reset,
    sel_overscan,
    sel_edges,
    sel_sprites,
    sel_palette,
    sel_multitap,
    sel_yb_map
  } reg_sel_e;

  // read data of the bridge clients outside the shell
  typedef struct packed {
    logic [31:0] cmd;
    logic [31:0] save;
    logic [31:0] state;
  } rd_src_t;

endpackage

//--- common/core_cfg.svh
////////////////////////////////////////////////////////////////////////////
// core shell configuration
// bridge register map, soft reset hold, video timing and widths
////////////////////////////////////////////////////////////////////////////

`ifndef CORE_CFG_SVH
`define CORE_CFG_SVH

// bridge write addresses, one 32-bit word each
`define CFG_ADDR_RESET     32'h0000_0050
`define CFG_ADDR_OVERSCAN  32'h0000_0200
`define CFG_ADDR_EDGES     32'h0000_0204
`define CFG_ADDR_SPRITES   32'h0000_0208
`define CFG_ADDR_PALETTE   32'h0000_020C
`define CFG_ADDR_MULTITAP  32'h0000_0300
`define CFG_ADDR_YB_MAP    32'h0000_0310

// soft reset hold, in clk_74a cycles
`define CFG_RESET_HOLD     32'h0010_0000

// rising core hsync to scaler hsync pulse
`define CFG_HS_DELAY       7
// slot colour word bit for hide overscan
`define CFG_SLOT_OVERSCAN_BIT 13

// read source selects on the upper address bits
`define CFG_SEL_CMD_HI     8'hF8
`define CFG_SEL_SAVE_NIB   4'h2
`define CFG_SEL_STATE_NIB  4'h4

`define CFG_KEY_W          16
`define CFG_RGB_W          24

`endif

//--- design/bridge/bridge_regs.sv
////////////////////////////////////////////////////////////////////////////
// bridge register block
// decodes host writes into core settings, runs the soft reset
// hold timer and selects bridge read data among external sources
////////////////////////////////////////////////////////////////////////////

`include "core_cfg.svh"

module bridge_regs
  import bridge_pkg::*;
(
  input  logic           clk_74a,
  input  logic           pll_core_locked,
  input  logic [31:0]    bridge_addr,
  input  logic           bridge_wr,
  input  logic [31:0]    bridge_wr_data,
  input  rd_src_t        rd_src,
  output logic [31:0]    bridge_rd_data,
  output core_settings_t settings,
  output logic           external_reset
);

  reg_sel_e    sel;
  logic [31:0] reset_cnt;
  logic        reset_wr;

  ////////////////////////////////////////////////////////////////////////////
  // write decode
  ////////////////////////////////////////////////////////////////////////////

  // exact word match on the register map
  always_comb begin
    case (bridge_addr)
      `CFG_ADDR_RESET:    sel = sel_reset;
      `CFG_ADDR_OVERSCAN: sel = sel_overscan;
      `CFG_ADDR_EDGES:    sel = sel_edges;
      `CFG_ADDR_SPRITES:  sel = sel_sprites;
      `CFG_ADDR_PALETTE:  sel = sel_palette;
      `CFG_ADDR_MULTITAP: sel = sel_multitap;
      `CFG_ADDR_YB_MAP:   sel = sel_yb_map;
      default:            sel = sel_none;
    endcase
  end

  assign reset_wr = bridge_wr && (sel == sel_reset);

  // settings registers, one field per address
  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      settings <= '0;
    end else if (bridge_wr) begin
      case (sel)
        sel_overscan: settings.hide_overscan       <= bridge_wr_data[0];
        sel_edges:    settings.mask_vid_edges      <= bridge_wr_data[1:0];
        sel_sprites:  settings.allow_extra_sprites <= bridge_wr_data[0];
        sel_palette:  settings.selected_palette    <= bridge_wr_data[2:0];
        sel_multitap: settings.multitap_enabled    <= bridge_wr_data[0];
        sel_yb_map:   settings.yb_map              <= bridge_wr_data[0];
        default:      settings                     <= settings;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // soft reset timer
  ////////////////////////////////////////////////////////////////////////////

  // reload wins over the countdown
  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      reset_cnt <= '0;
    end else if (reset_wr) begin
      reset_cnt <= `CFG_RESET_HOLD;
    end else if (reset_cnt != '0) begin
      reset_cnt <= reset_cnt - 32'd1;
    end
  end

  // held for exactly the load count
  assign external_reset = (reset_cnt != '0);

  ////////////////////////////////////////////////////////////////////////////
  // read mux
  ////////////////////////////////////////////////////////////////////////////

  // save-state range first, then save data, then command space
  always_comb begin
    if (bridge_addr[31:28] == `CFG_SEL_STATE_NIB) begin
      bridge_rd_data = rd_src.state;
    end else if (bridge_addr[31:28] == `CFG_SEL_SAVE_NIB) begin
      bridge_rd_data = rd_src.save;
    end else if (bridge_addr[31:24] == `CFG_SEL_CMD_HI) begin
      bridge_rd_data = rd_src.cmd;
    end else begin
      bridge_rd_data = '0;
    end
  end

  // core reset only starts from a host write to the reset word
  a_reset_needs_write : assert property (
    @(posedge clk_74a) disable iff (!pll_core_locked)
    $rose(external_reset) |-> $past(reset_wr)
  );

endmodule

//--- design/core_shell_top.sv
////////////////////////////////////////////////////////////////////////////
// core shell top level
// bridge registers, pad mapping and video conditioning on clk_74a
////////////////////////////////////////////////////////////////////////////

`include "core_cfg.svh"

module core_shell_top
  import bridge_pkg::*;
  import av_pkg::*;
(
  input  logic                       clk_74a,
  input  logic                       pll_core_locked,
  // bridge bus from the host
  input  logic [31:0]                bridge_addr,
  // read strobe belongs to the outside read clients, data is not gated by it
  input  logic                       bridge_rd,
  output logic [31:0]                bridge_rd_data,
  input  logic                       bridge_wr,
  input  logic [31:0]                bridge_wr_data,
  input  rd_src_t                    rd_src,
  // controllers
  input  logic [3:0][`CFG_KEY_W-1:0] cont_key,
  output pad_t [3:0]                 pads,
  // core control
  output core_settings_t             settings,
  output logic                       external_reset,
  // video
  input  raw_video_t                 raw_video,
  output scaler_video_t              scaler_video
);

  bridge_regs u_bridge_regs (
    .clk_74a        (clk_74a),
    .pll_core_locked(pll_core_locked),
    .bridge_addr    (bridge_addr),
    .bridge_wr      (bridge_wr),
    .bridge_wr_data (bridge_wr_data),
    .rd_src         (rd_src),
    .bridge_rd_data (bridge_rd_data),
    .settings       (settings),
    .external_reset (external_reset)
  );

  // remap only touches player 1
  pad_mapper u_pad_mapper (
    .cont_key(cont_key),
    .yb_map  (settings.yb_map),
    .pads    (pads)
  );

  video_conditioner u_video_conditioner (
    .clk_74a        (clk_74a),
    .pll_core_locked(pll_core_locked),
    .raw_video      (raw_video),
    .hide_overscan  (settings.hide_overscan),
    .scaler_video   (scaler_video)
  );

endmodule

//--- design/pad_mapper.sv
////////////////////////////////////////////////////////////////////////////
// controller to player pad mapping
// picks the core buttons out of each key bitmap, with an optional
// y/b remap on player 1
////////////////////////////////////////////////////////////////////////////

`include "core_cfg.svh"

module pad_mapper
  import av_pkg::*;
(
  input  logic [3:0][`CFG_KEY_W-1:0] cont_key,
  input  logic                       yb_map,
  output pad_t [3:0]                 pads
);

  // key bitmap positions
  localparam int KEY_UP     = 0;
  localparam int KEY_DOWN   = 1;
  localparam int KEY_LEFT   = 2;
  localparam int KEY_RIGHT  = 3;
  localparam int KEY_A      = 4;
  localparam int KEY_B      = 5;
  localparam int KEY_Y      = 7;
  localparam int KEY_SELECT = 14;
  localparam int KEY_START  = 15;

  always_comb begin
    for (int p = 0; p < 4; p++) begin
      pads[p].up     = cont_key[p][KEY_UP];
      pads[p].down   = cont_key[p][KEY_DOWN];
      pads[p].left   = cont_key[p][KEY_LEFT];
      pads[p].right  = cont_key[p][KEY_RIGHT];
      pads[p].start  = cont_key[p][KEY_START];
      pads[p].select = cont_key[p][KEY_SELECT];
      pads[p].a      = cont_key[p][KEY_A];
      pads[p].b      = cont_key[p][KEY_B];
    end
    // player 1 only, face b becomes a and y becomes b
    if (yb_map) begin
      pads[0].a = cont_key[0][KEY_B];
      pads[0].b = cont_key[0][KEY_Y];
    end
  end

endmodule

//--- design/video/video_conditioner.sv
////////////////////////////////////////////////////////////////////////////
// video conditioner
// turns raw core video into scaler timing with a registered de,
// a slot colour word after each line and single-cycle sync pulses
////////////////////////////////////////////////////////////////////////////

`include "core_cfg.svh"

module video_conditioner
  import av_pkg::*;
(
  input  logic          clk_74a,
  input  logic          pll_core_locked,
  input  raw_video_t    raw_video,
  input  logic          hide_overscan,
  output scaler_video_t scaler_video
);

  localparam int HS_CNT_W = $clog2(`CFG_HS_DELAY + 1);

  logic                  raw_de;
  logic                  de_prev;
  logic                  hs_prev;
  logic                  vs_prev;
  logic [HS_CNT_W-1:0]   hs_cnt;
  logic [`CFG_RGB_W-1:0] slot_rgb;

  // visible whenever neither blank is set
  assign raw_de = ~(raw_video.h_blank | raw_video.v_blank);

  // slot word carries the overscan flag to the scaler
  always_comb begin
    slot_rgb = '0;
    slot_rgb[`CFG_SLOT_OVERSCAN_BIT] = hide_overscan;
  end

  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      scaler_video <= '0;
      de_prev      <= 1'b0;
      hs_prev      <= 1'b0;
      vs_prev      <= 1'b0;
      hs_cnt       <= '0;
    end else begin
      scaler_video.de <= raw_de;

      // pixel data, then slot word on the first blank cycle
      if (raw_de) begin
        scaler_video.rgb <= raw_video.rgb;
      end else if (de_prev) begin
        scaler_video.rgb <= slot_rgb;
      end else begin
        scaler_video.rgb <= '0;
      end

      // hsync pushed out so it stays clear of vsync
      if (!hs_prev && raw_video.hs) begin
        hs_cnt <= HS_CNT_W'(`CFG_HS_DELAY);
      end else if (hs_cnt != '0) begin
        hs_cnt <= hs_cnt - 1'b1;
      end
      scaler_video.hs <= (hs_cnt == HS_CNT_W'(1));

      // vsync on the raw rising edge
      scaler_video.vs <= !vs_prev && raw_video.vs;

      de_prev <= raw_de;
      hs_prev <= raw_video.hs;
      vs_prev <= raw_video.vs;
    end
  end

  // scaler sync inputs are strictly single-cycle pulses
  a_hs_single : assert property (
    @(posedge clk_74a) disable iff (!pll_core_locked)
    scaler_video.hs |=> !scaler_video.hs
  );

  a_vs_single : assert property (
    @(posedge clk_74a) disable iff (!pll_core_locked)
    scaler_video.vs |=> !scaler_video.vs
  );

endmodule

//--- test/tb_core_shell.sv
////////////////////////////////////////////////////////////////////////////
// core shell testbench
// drives bridge, controller and raw video stimulus into the shell and
// checks every output against a cycle reference model with assertions
////////////////////////////////////////////////////////////////////////////

`include "core_cfg.svh"

module tb_core_shell
  import bridge_pkg::*;
  import av_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int HS_D     = `CFG_HS_DELAY;
  localparam int WD_LIMIT = `CFG_RESET_HOLD + 5000;

  logic                       clk_74a;
  logic                       pll_core_locked;
  logic [31:0]                bridge_addr;
  logic                       bridge_rd;
  logic [31:0]                bridge_rd_data;
  logic                       bridge_wr;
  logic [31:0]                bridge_wr_data;
  rd_src_t                    rd_src;
  logic [3:0][`CFG_KEY_W-1:0] cont_key;
  pad_t [3:0]                 pads;
  core_settings_t             settings;
  logic                       external_reset;
  raw_video_t                 raw_video;
  scaler_video_t              scaler_video;

  // reference model state
  core_settings_t        exp_settings;
  logic [31:0]           hold_left;
  logic [31:0]           exp_rd_data;
  pad_t [3:0]            exp_pads;
  scaler_video_t         exp_video;
  logic [`CFG_RGB_W-1:0] ref_slot;
  logic                  ref_hs_prev;
  logic                  ref_vs_prev;
  logic [HS_D-1:0]       hs_hist;
  logic [31:0]           rng;

  core_shell_top u_core_shell_top (.*);

  initial begin
    clk_74a = 1'b0;
    forever #2 clk_74a = ~clk_74a;
  end

  ////////////////////////////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] rand_word();
    rng = xorshift32(rng);
    return rng;
  endfunction

  // state range wins, then save range, then command byte
  function automatic logic [31:0] read_select(input logic [31:0] addr, input rd_src_t src);
    if (addr[31:28] == `CFG_SEL_STATE_NIB) return src.state;
    if (addr[31:28] == `CFG_SEL_SAVE_NIB) return src.save;
    if (addr[31:24] == `CFG_SEL_CMD_HI) return src.cmd;
    return 32'h0;
  endfunction

  function automatic pad_t [3:0] map_pads(input logic [3:0][`CFG_KEY_W-1:0] keys,
                                          input logic yb);
    pad_t [3:0] p;
    for (int i = 0; i < 4; i++) begin
      p[i] = '{a: keys[i][4], b: keys[i][5], start: keys[i][15], select: keys[i][14],
               up: keys[i][0], down: keys[i][1], left: keys[i][2], right: keys[i][3]};
    end
    if (yb) begin
      p[0].a = keys[0][5];
      p[0].b = keys[0][7];
    end
    return p;
  endfunction

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("=== FAIL ===");
    $fatal(1);
  endtask

  // one strobed write, driven on the falling edge
  task automatic bus_write(input logic [31:0] addr, input logic [31:0] data);
    @(negedge clk_74a);
    bridge_addr    = addr;
    bridge_wr_data = data;
    bridge_wr      = 1'b1;
    @(negedge clk_74a);
    bridge_wr      = 1'b0;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // reference model
  ////////////////////////////////////////////////////////////////////////////

  always @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      exp_settings <= '0;
      hold_left    <= '0;
    end else begin
      if (bridge_wr) begin
        case (bridge_addr)
          `CFG_ADDR_OVERSCAN: exp_settings.hide_overscan       <= bridge_wr_data[0];
          `CFG_ADDR_EDGES:    exp_settings.mask_vid_edges      <= bridge_wr_data[1:0];
          `CFG_ADDR_SPRITES:  exp_settings.allow_extra_sprites <= bridge_wr_data[0];
          `CFG_ADDR_PALETTE:  exp_settings.selected_palette    <= bridge_wr_data[2:0];
          `CFG_ADDR_MULTITAP: exp_settings.multitap_enabled    <= bridge_wr_data[0];
          `CFG_ADDR_YB_MAP:   exp_settings.yb_map              <= bridge_wr_data[0];
          default: ;
        endcase
      end
      // hold cycles still owed since the last reset write
      if (bridge_wr && bridge_addr == `CFG_ADDR_RESET) hold_left <= `CFG_RESET_HOLD;
      else if (hold_left != 0) hold_left <= hold_left - 1;
    end
  end

  assign exp_rd_data = read_select(bridge_addr, rd_src);
  assign exp_pads    = map_pads(cont_key, exp_settings.yb_map);
  assign ref_slot    = `CFG_RGB_W'(exp_settings.hide_overscan) << `CFG_SLOT_OVERSCAN_BIT;

  always @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      exp_video   <= '0;
      ref_hs_prev <= 1'b0;
      ref_vs_prev <= 1'b0;
      hs_hist     <= '0;
    end else begin
      exp_video.de <= !(raw_video.h_blank || raw_video.v_blank);
      if (!(raw_video.h_blank || raw_video.v_blank)) exp_video.rgb <= raw_video.rgb;
      else if (exp_video.de) exp_video.rgb <= ref_slot;
      else exp_video.rgb <= '0;
      exp_video.vs <= raw_video.vs && !ref_vs_prev;
      // hsync rise travels down a delay line
      hs_hist      <= {hs_hist[HS_D-2:0], raw_video.hs && !ref_hs_prev};
      exp_video.hs <= hs_hist[HS_D-1];
      ref_hs_prev  <= raw_video.hs;
      ref_vs_prev  <= raw_video.vs;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // checks
  ////////////////////////////////////////////////////////////////////////////

  a_settings : assert property (@(posedge clk_74a) disable iff (!pll_core_locked)
    settings == exp_settings)
    else fail_run($sformatf("MISMATCH time=%0t signal=settings expected=%h actual=%h",
                            $time, $sampled(exp_settings), $sampled(settings)));

  a_ext_reset : assert property (@(posedge clk_74a) disable iff (!pll_core_locked)
    external_reset == (hold_left != 0))
    else fail_run($sformatf("MISMATCH time=%0t signal=external_reset expected=%b actual=%b",
                            $time, $sampled(hold_left != 0), $sampled(external_reset)));

  a_rd_data : assert property (@(posedge clk_74a) disable iff (!pll_core_locked)
    bridge_rd_data == exp_rd_data)
    else fail_run($sformatf("MISMATCH time=%0t signal=bridge_rd_data expected=%h actual=%h",
                            $time, $sampled(exp_rd_data), $sampled(bridge_rd_data)));

  a_pads : assert property (@(posedge clk_74a) disable iff (!pll_core_locked)
    pads == exp_pads)
    else fail_run($sformatf("MISMATCH time=%0t signal=pads expected=%h actual=%h",
                            $time, $sampled(exp_pads), $sampled(pads)));

  a_video : assert property (@(posedge clk_74a) disable iff (!pll_core_locked)
    scaler_video == exp_video)
    else fail_run($sformatf("MISMATCH time=%0t signal=scaler_video expected=%h actual=%h",
                            $time, $sampled(exp_video), $sampled(scaler_video)));

  ////////////////////////////////////////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////////////////////////////////////////

  task automatic run_video(input int frames);
    logic [31:0] r;
    for (int f = 0; f < frames; f++) begin
      for (int y = 0; y < 8; y++) begin
        for (int x = 0; x < 40; x++) begin
          @(negedge clk_74a);
          r = rand_word();
          // occasional blank jitter gives extra falling de edges
          raw_video.h_blank = (x >= 32) || (r[27:24] == 4'h0);
          raw_video.v_blank = (y >= 6);
          raw_video.hs      = (x >= 34) && (x < 36);
          raw_video.vs      = (y == 7);
          raw_video.rgb     = r[23:0];
        end
      end
    end
  endtask

  initial begin
    int high_cycles;
    logic [31:0] set_addrs [6];
    logic [31:0] w;
    rng             = 32'd75;
    pll_core_locked = 1'b0;
    bridge_addr     = '0;
    bridge_rd       = 1'b0;
    bridge_wr       = 1'b0;
    bridge_wr_data  = '0;
    rd_src          = '0;
    cont_key        = '0;
    raw_video       = '0;
    set_addrs = '{`CFG_ADDR_OVERSCAN, `CFG_ADDR_EDGES, `CFG_ADDR_SPRITES,
                  `CFG_ADDR_PALETTE, `CFG_ADDR_MULTITAP, `CFG_ADDR_YB_MAP};
    repeat (16) @(posedge clk_74a);
    @(negedge clk_74a);
    pll_core_locked = 1'b1;
    repeat (4) @(negedge clk_74a);

    // settings fields, plus writes that decode to nothing
    for (int n = 0; n < 4; n++) begin
      foreach (set_addrs[i]) bus_write(set_addrs[i], rand_word());
      bus_write(32'h0000_0400, rand_word());
      bus_write(32'hF800_0200, rand_word());
    end

    // read mux over each select range
    bridge_rd = 1'b1;
    for (int i = 0; i < 18; i++) begin
      @(negedge clk_74a);
      rd_src = {rand_word(), rand_word(), rand_word()};
      w = rand_word();
      case (i % 6)
        0: bridge_addr = {`CFG_SEL_STATE_NIB, w[27:0]};
        1: bridge_addr = {`CFG_SEL_SAVE_NIB, w[27:0]};
        2: bridge_addr = {`CFG_SEL_CMD_HI, w[23:0]};
        3: bridge_addr = 32'hF800_0000;
        4: bridge_addr = 32'h0000_00F8;
        default: bridge_addr = w;
      endcase
    end
    bridge_rd = 1'b0;

    // pads with and without the player 1 remap
    for (int yb = 0; yb < 2; yb++) begin
      bus_write(`CFG_ADDR_YB_MAP, yb);
      repeat (16) begin
        @(negedge clk_74a);
        cont_key = {rand_word(), rand_word()};
      end
    end

    // video with both slot word flavours
    for (int h = 0; h < 2; h++) begin
      bus_write(`CFG_ADDR_OVERSCAN, h);
      run_video(2);
    end

    // soft reset, reloaded partway through the hold
    bus_write(`CFG_ADDR_RESET, rand_word());
    repeat (500) @(negedge clk_74a);
    bus_write(`CFG_ADDR_RESET, rand_word());
    high_cycles = 0;
    while (external_reset) begin
      high_cycles++;
      @(negedge clk_74a);
    end
    repeat (8) @(negedge clk_74a);
    if (high_cycles == `CFG_RESET_HOLD) begin
      $display("=== PASS ===");
      $finish;
    end else begin
      fail_run($sformatf(
        "MISMATCH time=%0t signal=external_reset_cycles expected=%0d actual=%0d",
        $time, `CFG_RESET_HOLD, high_cycles));
    end
  end

  // watchdog sized to the soft reset hold plus the shorter tests
  initial begin
    repeat (WD_LIMIT) @(posedge clk_74a);
    fail_run("watchdog expired before the test sequence finished");
  end

endmodule

//--- vlog.f
+incdir+common
common/bridge_pkg.sv
common/av_pkg.sv
design/bridge/bridge_regs.sv
design/pad_mapper.sv
design/video/video_conditioner.sv
design/core_shell_top.sv
test/tb_core_shell.sv
